//--- common/stepGame_settings.svh
`ifndef STEP_GAME_SETTINGS_SVH
`define STEP_GAME_SETTINGS_SVH

// horizontal timing, in pixel clocks
`define H_ACTIVE 640 // visible pixels per line
`define H_FRONT 16 // front porch
`define H_SYNC 96 // hsync pulse width
`define H_BACK 48 // back porch

// vertical timing, in lines
`define V_ACTIVE 480 // visible lines per frame
`define V_FRONT 10 // front porch
`define V_SYNC 2 // vsync pulse width
`define V_BACK 33 // back porch

// playfield grid
`define GRID_COLS 10 // tiles across
`define GRID_ROWS 7 // tiles down
`define TILE_WIDTH 64 // power of two, column is taken from pixelX bits
`define TILE_HEIGHT 68 // not a power of two, rows are counted

// step rectangle inside a tile, relative to the tile corner
`define STEP_OFFSET_X 7 // left edge offset
`define STEP_OFFSET_Y 50 // top edge offset
`define STEP_WIDTH 50 // exclusive right edge at offset + width
`define STEP_HEIGHT 7 // exclusive bottom edge at offset + height

// colors, RRRGGGBB
`define STEP_COLOR 8'h5b // step body
`define BACKGROUND_COLOR 8'h00 // empty playfield
`define BLANK_COLOR 8'h00 // must be black during blanking

`endif

//--- common/stepGamePkg.sv
package stepGamePkg;

	// step kind stored per tile in the map
	typedef enum logic [2:0] {
		FREE    = 3'd0, // nothing drawn in this tile
		REGULAR = 3'd1  // plain step rectangle
	} stepKind; // codes 2 to 7 reserved, they draw nothing

	// screen coordinate, wide enough for the whole 800 x 525 raster
	typedef logic [10:0] pixelCoord;

	// tile column index, 0 to 9 on the grid
	typedef logic [3:0] tileCol;

	// tile row index, 0 to 6 on the grid, 7 is below the grid
	typedef logic [2:0] tileRow;

	// 8-bit color, RRRGGGBB
	typedef logic [7:0] rgbColor;

endpackage

//--- hw/vgaTiming.sv
`include "stepGame_settings.svh"

module vgaTiming (
	input logic clk, // pixel clock
	input logic resetN,
	output stepGamePkg::pixelCoord pixelX, // current beam column
	output stepGamePkg::pixelCoord pixelY, // current beam line
	output logic active, // beam inside the visible 640 x 480 area
	output logic hsync, // active low, delayed to line up with rgb
	output logic vsync // active low, delayed to line up with rgb
);
	import stepGamePkg::*;

	// raster totals
	localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK; // 800
	localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK; // 525

	// sync windows, start inclusive and end exclusive
	localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT; // 656
	localparam int H_SYNC_END = H_SYNC_START + `H_SYNC; // 752
	localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT; // 490
	localparam int V_SYNC_END = V_SYNC_START + `V_SYNC; // 492

	pixelCoord hCount; // pixel within line
	pixelCoord vCount; // line within frame
	logic lineEnd; // last pixel of the line
	logic frameEnd; // last line of the frame
	logic hsyncRaw; // undelayed sync decode
	logic vsyncRaw;
	logic [1:0] hsyncPipe; // two stages, matches drawingRequest and rgb
	logic [1:0] vsyncPipe;

	assign lineEnd = (hCount == pixelCoord'(H_TOTAL - 1));
	assign frameEnd = (vCount == pixelCoord'(V_TOTAL - 1));

	// raster counters, (0,0) is presented right out of reset
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hCount <= '0;
			vCount <= '0;
		end else if (lineEnd) begin
			hCount <= '0; // wrap at 800
			if (frameEnd)
				vCount <= '0; // wrap at 525
			else
				vCount <= vCount + 1'b1;
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	assign pixelX = hCount;
	assign pixelY = vCount;
	assign active = (hCount < pixelCoord'(`H_ACTIVE)) && (vCount < pixelCoord'(`V_ACTIVE));

	// sync decode, low inside the pulse window
	assign hsyncRaw = !((hCount >= pixelCoord'(H_SYNC_START)) &&
		(hCount < pixelCoord'(H_SYNC_END)));
	assign vsyncRaw = !((vCount >= pixelCoord'(V_SYNC_START)) &&
		(vCount < pixelCoord'(V_SYNC_END)));

	// delay the pulses by the two renderer stages
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hsyncPipe <= 2'b11; // inactive out of reset
			vsyncPipe <= 2'b11;
		end else begin
			hsyncPipe <= {hsyncPipe[0], hsyncRaw};
			vsyncPipe <= {vsyncPipe[0], vsyncRaw};
		end
	end

	assign hsync = hsyncPipe[1];
	assign vsync = vsyncPipe[1];

endmodule

//--- hw/tileLocator.sv
`include "stepGame_settings.svh"

module tileLocator (
	input logic clk,
	input logic resetN,
	input stepGamePkg::pixelCoord pixelX, // current beam column
	input stepGamePkg::pixelCoord pixelY, // current beam line
	output stepGamePkg::pixelCoord tileTopLeftX, // left edge of the tile under the beam
	output stepGamePkg::pixelCoord tileTopLeftY, // top edge of the tile row
	output stepGamePkg::tileCol curCol, // column index for the map read
	output stepGamePkg::tileRow curRow // row index, GRID_ROWS below the grid
);
	import stepGamePkg::*;

	localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
	localparam int COL_SHIFT = $clog2(`TILE_WIDTH); // 6 for 64 wide tiles

	logic [6:0] lineInTile; // 0 to 67 inside the current row
	tileRow rowReg; // row of the current line
	pixelCoord rowTopY; // running top edge of rowReg
	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (pixelX == pixelCoord'(H_TOTAL - 1));
	assign frameEnd = (pixelY == pixelCoord'(V_TOTAL - 1));

	// columns are straight from the upper pixelX bits
	assign curCol = tileCol'(pixelX >> COL_SHIFT); // reaches 12 in blanking, map treats as off grid
	assign tileTopLeftX = pixelX & ~pixelCoord'(`TILE_WIDTH - 1); // round down to tile edge

	// rows are counted since 68 is not a power of two
	// state changes on the last pixel so the whole next line sees it
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lineInTile <= '0;
			rowReg <= '0;
			rowTopY <= '0;
		end else if (lineEnd) begin
			if (frameEnd) begin
				lineInTile <= '0; // back to row 0 for the new frame
				rowReg <= '0;
				rowTopY <= '0;
			end else if (lineInTile == 7'(`TILE_HEIGHT - 1)) begin
				lineInTile <= '0; // crossing into the next row
				if (rowReg < tileRow'(`GRID_ROWS)) begin // hold at the below-grid row
					rowReg <= rowReg + 1'b1;
					rowTopY <= rowTopY + pixelCoord'(`TILE_HEIGHT);
				end
			end else begin
				lineInTile <= lineInTile + 1'b1;
			end
		end
	end

	assign curRow = rowReg;
	assign tileTopLeftY = rowTopY;

endmodule

//--- hw/stepMap.sv
`include "stepGame_settings.svh"

module stepMap (
	input logic clk,
	input logic resetN,
	input logic mapWrEn, // write strobe from the game controller
	input stepGamePkg::tileCol mapWrCol,
	input stepGamePkg::tileRow mapWrRow,
	input stepGamePkg::stepKind mapWrKind,
	input stepGamePkg::tileCol curCol, // read address from tileLocator
	input stepGamePkg::tileRow curRow,
	output stepGamePkg::stepKind curKind // kind of the tile under the beam
);
	import stepGamePkg::*;

	stepKind mapRegs [`GRID_ROWS][`GRID_COLS]; // 70 tiles, row major
	logic wrInRange; // write address on the grid
	logic rdInRange; // read address on the grid

	assign wrInRange = (mapWrCol < tileCol'(`GRID_COLS)) && (mapWrRow < tileRow'(`GRID_ROWS));
	assign rdInRange = (curCol < tileCol'(`GRID_COLS)) && (curRow < tileRow'(`GRID_ROWS));

	// map is all FREE after reset, off-grid writes are dropped
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int r = 0; r < `GRID_ROWS; r++) begin
				for (int c = 0; c < `GRID_COLS; c++) begin
					mapRegs[r][c] <= FREE;
				end
			end
		end else if (mapWrEn && wrInRange) begin
			mapRegs[mapWrRow][mapWrCol] <= mapWrKind; // visible to reads next cycle
		end
	end

	// same-cycle read, anything off the grid is FREE
	always_comb begin
		if (rdInRange)
			curKind = mapRegs[curRow][curCol];
		else
			curKind = FREE; // covers the strip below row 6 and the blanking columns
	end

endmodule

//--- hw/regularStep.sv
`include "stepGame_settings.svh"

module regularStep (
	input logic clk,
	input logic resetN,
	input stepGamePkg::pixelCoord pixelX, // current beam column
	input stepGamePkg::pixelCoord pixelY, // current beam line
	input stepGamePkg::pixelCoord tileTopLeftX, // corner of the tile under the beam
	input stepGamePkg::pixelCoord tileTopLeftY,
	input stepGamePkg::stepKind curKind, // kind of that tile
	output logic drawingRequest // pixel belongs to a regular step, one cycle later
);
	import stepGamePkg::*;

	pixelCoord stepLeft; // inclusive
	pixelCoord stepTop; // inclusive
	pixelCoord stepRight; // exclusive
	pixelCoord stepBottom; // exclusive
	logic insideStep; // beam inside the step rectangle

	// rectangle edges relative to the tile corner
	assign stepLeft = tileTopLeftX + pixelCoord'(`STEP_OFFSET_X);
	assign stepTop = tileTopLeftY + pixelCoord'(`STEP_OFFSET_Y);
	assign stepRight = stepLeft + pixelCoord'(`STEP_WIDTH);
	assign stepBottom = stepTop + pixelCoord'(`STEP_HEIGHT);

	assign insideStep = (pixelX >= stepLeft) && (pixelX < stepRight) &&
		(pixelY >= stepTop) && (pixelY < stepBottom);

	// only REGULAR tiles draw, FREE and reserved codes stay clear
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			drawingRequest <= 1'b0;
		else
			drawingRequest <= (curKind == REGULAR) && insideStep;
	end

endmodule

//--- hw/objectMux.sv
`include "stepGame_settings.svh"

module objectMux (
	input logic clk,
	input logic resetN,
	input logic active, // visible area flag, same cycle as the pixel
	input logic drawingRequest, // step request, one cycle after the pixel
	output stepGamePkg::rgbColor rgb // final color, two cycles after the pixel
);
	import stepGamePkg::*;

	logic activeD; // active lined up with drawingRequest

	// blanking wins, then the step, then the background
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			activeD <= 1'b0;
			rgb <= '0; // black out of reset
		end else begin
			activeD <= active;
			if (!activeD)
				rgb <= rgbColor'(`BLANK_COLOR);
			else if (drawingRequest)
				rgb <= rgbColor'(`STEP_COLOR);
			else
				rgb <= rgbColor'(`BACKGROUND_COLOR);
		end
	end

endmodule

//--- hw/stepGameTop.sv
module stepGameTop (
	input logic clk, // pixel clock
	input logic resetN,
	input logic mapWrEn, // map write strobe
	input stepGamePkg::tileCol mapWrCol,
	input stepGamePkg::tileRow mapWrRow,
	input stepGamePkg::stepKind mapWrKind,
	output stepGamePkg::rgbColor rgb, // to the DAC
	output logic hsync, // active low
	output logic vsync // active low
);
	import stepGamePkg::*;

	pixelCoord pixelX; // beam position
	pixelCoord pixelY;
	logic active;
	pixelCoord tileTopLeftX; // tile corner under the beam
	pixelCoord tileTopLeftY;
	tileCol curCol; // map read address
	tileRow curRow;
	stepKind curKind; // map read data
	logic drawingRequest;

	vgaTiming vgaTiming_inst (
		.clk(clk),
		.resetN(resetN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.active(active),
		.hsync(hsync),
		.vsync(vsync)
	);

	tileLocator tileLocator_inst (
		.clk(clk),
		.resetN(resetN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.tileTopLeftX(tileTopLeftX),
		.tileTopLeftY(tileTopLeftY),
		.curCol(curCol),
		.curRow(curRow)
	);

	stepMap stepMap_inst (
		.clk(clk),
		.resetN(resetN),
		.mapWrEn(mapWrEn),
		.mapWrCol(mapWrCol),
		.mapWrRow(mapWrRow),
		.mapWrKind(mapWrKind),
		.curCol(curCol),
		.curRow(curRow),
		.curKind(curKind)
	);

	regularStep regularStep_inst (
		.clk(clk),
		.resetN(resetN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.tileTopLeftX(tileTopLeftX),
		.tileTopLeftY(tileTopLeftY),
		.curKind(curKind),
		.drawingRequest(drawingRequest)
	);

	objectMux objectMux_inst (
		.clk(clk),
		.resetN(resetN),
		.active(active),
		.drawingRequest(drawingRequest),
		.rgb(rgb)
	);

endmodule

//--- verif/stepGameModel.svh
`ifndef STEP_GAME_MODEL_SVH
`define STEP_GAME_MODEL_SVH

`include "stepGame_settings.svh"

logic [2:0] shadowMap [`GRID_ROWS][`GRID_COLS]; // mirror of the DUT map, row then column

// all tiles back to FREE, same as the DUT after reset
function automatic void clearShadow();
	for (int r = 0; r < `GRID_ROWS; r++) begin
		for (int c = 0; c < `GRID_COLS; c++) begin
			shadowMap[3'(r)][4'(c)] = 3'(FREE);
		end
	end
endfunction

// apply one write as the map should see it, off-grid addresses change nothing
function automatic void recordWrite(input int col, input int row, input logic [2:0] kind);
	if (col < `GRID_COLS && row < `GRID_ROWS)
		shadowMap[3'(row)][4'(col)] = kind;
endfunction

// color of screen pixel (x,y) for a given map
function automatic logic [7:0] expectedColor(input int x, input int y,
		input logic [2:0] mapKinds [`GRID_ROWS][`GRID_COLS]);
	int col;
	int row;
	int inX;
	int inY;
	col = x / `TILE_WIDTH;
	row = y / `TILE_HEIGHT; // 7 for lines 476 to 479
	inX = x - col * `TILE_WIDTH; // position inside the tile
	inY = y - row * `TILE_HEIGHT;
	if (x >= `H_ACTIVE || y >= `V_ACTIVE)
		return `BLANK_COLOR;
	if (col >= `GRID_COLS || row >= `GRID_ROWS)
		return `BACKGROUND_COLOR; // strip below the grid
	if (mapKinds[3'(row)][4'(col)] == REGULAR &&
			inX >= `STEP_OFFSET_X && inX < `STEP_OFFSET_X + `STEP_WIDTH &&
			inY >= `STEP_OFFSET_Y && inY < `STEP_OFFSET_Y + `STEP_HEIGHT)
		return `STEP_COLOR;
	return `BACKGROUND_COLOR; // FREE and reserved kinds
endfunction

// sync levels, low inside the pulse
function automatic logic expectedHsync(input int x);
	return !(x >= `H_ACTIVE + `H_FRONT && x < `H_ACTIVE + `H_FRONT + `H_SYNC);
endfunction

function automatic logic expectedVsync(input int y);
	return !(y >= `V_ACTIVE + `V_FRONT && y < `V_ACTIVE + `V_FRONT + `V_SYNC);
endfunction

`endif

//--- verif/stepGameTb.sv
`include "stepGame_settings.svh"

module stepGameTb;
	import stepGamePkg::*;

	localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK; // 800
	localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK; // 525
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 1000; // 1,261,000
	localparam int RANDOM_SEED = 32'h2b3a_bfda;

	logic clk;
	logic resetN;
	logic mapWrEn;
	tileCol mapWrCol;
	tileRow mapWrRow;
	stepKind mapWrKind;
	rgbColor rgb;
	logic hsync;
	logic vsync;

	int cycleCount = 0;
	int tbX = 0; // pixel on the DUT counters this cycle
	int tbY = 0;
	int frameNum = 1;
	logic exp1Valid = 1'b0; // pixel registered one edge ago
	rgbColor exp1Rgb;
	logic exp1Hsync;
	logic exp1Vsync;
	int exp1X;
	int exp1Y;
	int exp1Frame;
	logic exp2Valid = 1'b0; // pixel whose rgb is on the output now
	rgbColor exp2Rgb;
	logic exp2Hsync;
	logic exp2Vsync;
	int exp2X;
	int exp2Y;
	int exp2Frame;
	int stepPixelCount = 0;

	`include "stepGameModel.svh"

	stepGameTop stepGameTop_inst (
		.clk(clk),
		.resetN(resetN),
		.mapWrEn(mapWrEn),
		.mapWrCol(mapWrCol),
		.mapWrRow(mapWrRow),
		.mapWrKind(mapWrKind),
		.rgb(rgb),
		.hsync(hsync),
		.vsync(vsync)
	);

	always #50 clk = ~clk; // period 100

	task automatic stopWithFailure();
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic reportMismatch(input string signalName, input logic [7:0] expected,
			input logic [7:0] actual);
		$display("mismatch at time %0t: %s expected %0h, actual %0h (pixel %0d,%0d frame %0d)",
			$time, signalName, expected, actual, exp2X, exp2Y, exp2Frame);
		stopWithFailure();
	endtask

	// one write per call, starts and ends on a falling edge
	task automatic writeTile(input logic [3:0] col, input logic [2:0] row,
			input logic [2:0] kind);
		mapWrCol = col;
		mapWrRow = row;
		mapWrKind = stepKind'(kind); // reserved codes pass through the cast
		mapWrEn = 1'b1;
		@(negedge clk);
		mapWrEn = 1'b0;
	endtask

	task automatic waitForLine(input int frame, input int line);
		while (!(frameNum == frame && tbY == line))
			@(negedge clk);
	endtask

	task automatic writeRandomTiles(input int count);
		logic [3:0] col;
		logic [2:0] row;
		logic [2:0] kind;
		for (int i = 0; i < count; i++) begin
			col = 4'($urandom % `GRID_COLS);
			row = 3'($urandom % `GRID_ROWS);
			if (i % 3 == 0)
				kind = 3'(REGULAR); // keeps enough steps on screen
			else
				kind = 3'($urandom % 8); // any code, reserved ones too
			writeTile(col, row, kind);
		end
	endtask

	// addresses the map must drop
	task automatic writeOffGrid();
		for (int i = 0; i < 6; i++)
			writeTile(4'(`GRID_COLS + ($urandom % 6)), 3'($urandom % 8), 3'(REGULAR));
		for (int i = 0; i < 4; i++)
			writeTile(4'($urandom % `GRID_COLS), 3'(`GRID_ROWS), 3'(REGULAR));
	endtask

	// swap some REGULAR tiles to FREE and some FREE tiles to REGULAR
	task automatic flipTiles();
		for (int r = 0; r < `GRID_ROWS; r++) begin
			for (int c = 0; c < `GRID_COLS; c++) begin
				if ($urandom % 3 == 0) begin
					if (shadowMap[3'(r)][4'(c)] == REGULAR)
						writeTile(4'(c), 3'(r), 3'(FREE));
					else if (shadowMap[3'(r)][4'(c)] == FREE)
						writeTile(4'(c), 3'(r), 3'(REGULAR));
				end
			end
		end
		writeTile(4'd0, 3'(`GRID_ROWS - 1), 3'(REGULAR)); // last grid row
		writeTile(4'd5, 3'(`GRID_ROWS - 1), 3'(REGULAR));
		writeTile(4'(`GRID_COLS - 1), 3'(`GRID_ROWS - 1), 3'(REGULAR));
	endtask

	// stimulus, all on the falling edge
	initial begin
		void'($urandom(RANDOM_SEED));
		clk = 1'b0;
		resetN = 1'b0;
		mapWrEn = 1'b0;
		mapWrCol = '0;
		mapWrRow = '0;
		mapWrKind = FREE;
		repeat (3) @(negedge clk);
		resetN = 1'b1;
		waitForLine(1, `V_ACTIVE + 1); // frame 1 active area stays empty
		writeRandomTiles(40);
		waitForLine(2, `V_ACTIVE + 1); // between frames 2 and 3
		writeOffGrid();
		flipTiles();
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("timeout: frame 3 not finished after %0d cycles", cycleCount);
			stopWithFailure();
		end
	end

	// reference pipeline, follows the pixel through the two DUT stages
	always @(posedge clk) begin
		if (!resetN) begin
			clearShadow();
			tbX = 0;
			tbY = 0;
			frameNum = 1;
			exp1Valid = 1'b0;
			exp2Valid = 1'b0;
		end else begin
			exp2Valid = exp1Valid;
			exp2Rgb = exp1Rgb;
			exp2Hsync = exp1Hsync;
			exp2Vsync = exp1Vsync;
			exp2X = exp1X;
			exp2Y = exp1Y;
			exp2Frame = exp1Frame;
			exp1Valid = 1'b1;
			exp1Rgb = expectedColor(tbX, tbY, shadowMap); // map as read before this edge
			exp1Hsync = expectedHsync(tbX);
			exp1Vsync = expectedVsync(tbY);
			exp1X = tbX;
			exp1Y = tbY;
			exp1Frame = frameNum;
			if (mapWrEn)
				recordWrite(int'(mapWrCol), int'(mapWrRow), mapWrKind);
			if (tbX == H_TOTAL - 1) begin
				tbX = 0;
				if (tbY == V_TOTAL - 1) begin
					tbY = 0;
					frameNum++;
				end else begin
					tbY++;
				end
			end else begin
				tbX++;
			end
		end
	end

	// compare on the falling edge where outputs are settled
	always @(negedge clk) begin
		if (!exp2Valid) begin // reset and first cycle after
			assert (rgb === 8'h00) else reportMismatch("rgb", 8'h00, rgb);
			assert (hsync === 1'b1) else reportMismatch("hsync", 8'h01, {7'd0, hsync});
			assert (vsync === 1'b1) else reportMismatch("vsync", 8'h01, {7'd0, vsync});
		end else begin
			assert (rgb === exp2Rgb) else reportMismatch("rgb", exp2Rgb, rgb);
			assert (hsync === exp2Hsync)
				else reportMismatch("hsync", {7'd0, exp2Hsync}, {7'd0, hsync});
			assert (vsync === exp2Vsync)
				else reportMismatch("vsync", {7'd0, exp2Vsync}, {7'd0, vsync});
			if (rgb === `STEP_COLOR)
				stepPixelCount++;
			if (exp2X == H_TOTAL - 1 && exp2Y == V_TOTAL - 1) begin // frame done
				assert (exp2Frame == 1 || stepPixelCount > 0) else begin
					$display("no step pixels were drawn in frame %0d", exp2Frame);
					stopWithFailure();
				end
				stepPixelCount = 0;
				if (exp2Frame == 3) begin
					$display("*** PASSED ***");
					$finish;
				end
			end
		end
	end

endmodule

//--- list.f
+incdir+common
+incdir+verif
common/stepGamePkg.sv
hw/vgaTiming.sv
hw/tileLocator.sv
hw/stepMap.sv
hw/regularStep.sv
hw/objectMux.sv
hw/stepGameTop.sv
verif/stepGameTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= stepGameTb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert
EXTRA_FLAGS ?=

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILE_LIST BUILD_DIR JOBS VFLAGS EXTRA_FLAGS"

$(SIM): $(FILE_LIST) $(shell grep -v '^+' $(FILE_LIST)) common/stepGame_settings.svh \
		verif/stepGameModel.svh
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
